//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // RV64 integer datapath widths
    localparam int XLEN      = 64;
    localparam int SHAMT_W   = $clog2(XLEN);
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ALU operations, shifts use the low six bits of src2
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Access size as in funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_LOAD  = 2'd1,
        CMD_STORE = 2'd2
    } mem_cmd_e;

endpackage

//--- hdl/mem_access_pkg.sv
package mem_access_pkg;

    // Byte lanes of one doubleword
    localparam int LANES      = 8;
    localparam int LANE_IDX_W = $clog2(LANES);

    // Default data memory depth in doublewords
    localparam int DMEM_WORDS_DFLT = 32;

    // One write enable per byte lane
    typedef logic [LANES-1:0] wstrb_t;

    // Byte selects in [7:0], sign extend request in [8]
    typedef logic [LANES:0] rstrb_t;

    // Source of the value written back to the register file
    typedef enum logic [2:0] {
        SEL_NONE = 3'd0,
        SEL_ALU  = 3'd1,
        SEL_LOAD = 3'd2,
        SEL_LINK = 3'd3
    } regin_sel_e;

endpackage

//--- hdl/ex_stage.sv
`timescale 1ns/10ps

module ex_stage
    import rv_isa_pkg::*;
    import mem_access_pkg::*;
(
    input  logic       I_sys_clk,
    input  logic       I_rst,
    input  logic       issue_valid,
    output logic       issue_allowin,
    input  alu_op_e    issue_op,
    input  mem_cmd_e   issue_cmd,
    input  mem_size_e  issue_size,
    input  logic       issue_unsigned,
    input  logic       issue_link,
    input  xlen_t      issue_src1,
    input  xlen_t      issue_src2,
    input  xlen_t      issue_imm,
    input  xlen_t      issue_pc,
    input  reg_idx_t   issue_rd,
    input  logic       ex_allowin,
    output logic       ex_valid,
    output xlen_t      alu_out,
    output xlen_t      mem_addr,
    output xlen_t      rs2_data,
    output xlen_t      pc,
    output wstrb_t     wstrb,
    output rstrb_t     rstrb,
    output logic       mem_wen,
    output logic       reg_wen,
    output reg_idx_t   rd_addr,
    output regin_sel_e regin_sel
);

    logic      full;
    alu_op_e   op_q;
    mem_cmd_e  cmd_q;
    mem_size_e size_q;
    logic      unsigned_q;
    logic      link_q;
    xlen_t     src1_q;
    xlen_t     src2_q;
    xlen_t     imm_q;
    reg_idx_t  rd_q;
    wstrb_t    size_mask;
    wstrb_t    lane_mask;

    assign issue_allowin = !full || ex_allowin;
    assign ex_valid      = full;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            full  <= 1'b0;
            cmd_q <= CMD_NONE;
            rd_q  <= '0;
        end else if (issue_allowin) begin
            full <= issue_valid;
            if (issue_valid) begin
                cmd_q <= issue_cmd;
                rd_q  <= issue_rd;
            end
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (issue_valid && issue_allowin) begin
            op_q       <= issue_op;
            size_q     <= issue_size;
            unsigned_q <= issue_unsigned;
            link_q     <= issue_link;
            src1_q     <= issue_src1;
            src2_q     <= issue_src2;
            imm_q      <= issue_imm;
            pc         <= issue_pc;
        end
    end

    always_comb begin
        case (op_q)
            ALU_ADD:  alu_out = src1_q + src2_q;
            ALU_SUB:  alu_out = src1_q - src2_q;
            ALU_AND:  alu_out = src1_q & src2_q;
            ALU_OR:   alu_out = src1_q | src2_q;
            ALU_XOR:  alu_out = src1_q ^ src2_q;
            ALU_SLL:  alu_out = src1_q << src2_q[SHAMT_W-1:0];
            ALU_SRL:  alu_out = src1_q >> src2_q[SHAMT_W-1:0];
            ALU_SRA:  alu_out = $signed(src1_q) >>> src2_q[SHAMT_W-1:0];
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(src1_q) < $signed(src2_q)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, src1_q < src2_q};
            default:  alu_out = '0;
        endcase
    end

    assign mem_addr = src1_q + imm_q;
    assign rs2_data = src2_q;

    always_comb begin
        case (size_q)
            SIZE_B:  size_mask = 8'h01;
            SIZE_H:  size_mask = 8'h03;
            SIZE_W:  size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // Bytes of the doubleword touched by the access
    assign lane_mask = size_mask << mem_addr[LANE_IDX_W-1:0];

    assign wstrb = (cmd_q == CMD_STORE) ? lane_mask : '0;
    assign rstrb = (cmd_q == CMD_LOAD) ? {!unsigned_q, lane_mask} : '0;

    assign mem_wen = (cmd_q == CMD_STORE);
    assign reg_wen = (cmd_q != CMD_STORE) && (rd_q != '0);
    assign rd_addr = rd_q;

    always_comb begin
        if (cmd_q == CMD_LOAD)
            regin_sel = SEL_LOAD;
        else if (cmd_q == CMD_STORE)
            regin_sel = SEL_NONE;
        else if (link_q)
            regin_sel = SEL_LINK;
        else
            regin_sel = SEL_ALU;
    end

endmodule

//--- hdl/ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg
    import rv_isa_pkg::*;
    import mem_access_pkg::*;
(
    input  logic       I_sys_clk,
    input  logic       I_rst,
    input  logic       ex_valid,
    output logic       ex_allowin,
    input  xlen_t      ex_alu_out,
    input  xlen_t      ex_mem_addr,
    input  xlen_t      ex_rs2_data,
    input  wstrb_t     ex_wstrb,
    input  rstrb_t     ex_rstrb,
    input  logic       ex_mem_wen,
    input  logic       ex_reg_wen,
    input  reg_idx_t   ex_rd_addr,
    input  regin_sel_e ex_regin_sel,
    input  xlen_t      ex_pc,
    output logic       mem_valid,
    input  logic       mem_allowin,
    output xlen_t      mem_alu_out,
    output xlen_t      mem_mem_addr,
    output xlen_t      mem_rs2_data,
    output wstrb_t     mem_wstrb,
    output rstrb_t     mem_rstrb,
    output logic       mem_mem_wen,
    output logic       mem_reg_wen,
    output reg_idx_t   mem_rd_addr,
    output regin_sel_e mem_regin_sel,
    output xlen_t      mem_pc
);

    logic full;

    assign ex_allowin = !full || mem_allowin;
    assign mem_valid  = full;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            full <= 1'b0;
        else if (ex_allowin)
            full <= ex_valid;
    end

    // Write enables start cleared, the rest loads only on transfer
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mem_mem_wen <= 1'b0;
            mem_reg_wen <= 1'b0;
        end else if (ex_valid && ex_allowin) begin
            mem_mem_wen <= ex_mem_wen;
            mem_reg_wen <= ex_reg_wen;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (ex_valid && ex_allowin) begin
            mem_alu_out   <= ex_alu_out;
            mem_mem_addr  <= ex_mem_addr;
            mem_rs2_data  <= ex_rs2_data;
            mem_wstrb     <= ex_wstrb;
            mem_rstrb     <= ex_rstrb;
            mem_rd_addr   <= ex_rd_addr;
            mem_regin_sel <= ex_regin_sel;
            mem_pc        <= ex_pc;
        end
    end

    // A stalled operation must reach mem_stage unchanged
    a_hold_stalled: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        mem_valid && !mem_allowin |=> $stable({mem_alu_out, mem_mem_addr, mem_rs2_data,
            mem_wstrb, mem_rstrb, mem_mem_wen, mem_reg_wen, mem_rd_addr, mem_regin_sel,
            mem_pc}));

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage
    import rv_isa_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int DMEM_WORDS = DMEM_WORDS_DFLT
) (
    input  logic       I_sys_clk,
    input  logic       I_rst,
    input  logic       mem_valid,
    output logic       mem_allowin,
    input  xlen_t      mem_alu_out,
    input  xlen_t      mem_mem_addr,
    input  xlen_t      mem_rs2_data,
    input  wstrb_t     mem_wstrb,
    input  rstrb_t     mem_rstrb,
    input  logic       mem_mem_wen,
    input  logic       mem_reg_wen,
    input  reg_idx_t   mem_rd_addr,
    input  regin_sel_e mem_regin_sel,
    input  xlen_t      mem_pc,
    output logic       wb_valid,
    input  logic       wb_allowout,
    output logic       wb_reg_wen,
    output reg_idx_t   wb_rd,
    output xlen_t      wb_data
);

    localparam int AW = $clog2(DMEM_WORDS);

    xlen_t                 dmem [DMEM_WORDS];
    logic                  full;
    logic                  accept;
    logic [AW-1:0]         word_idx;
    logic [LANE_IDX_W-1:0] byte_off;
    xlen_t                 store_lanes;
    xlen_t                 rd_word;
    xlen_t                 rd_shifted;
    wstrb_t                low_mask;
    logic                  load_sign;
    xlen_t                 load_data;
    xlen_t                 wb_next;
    wstrb_t                access_strb;

    assign mem_allowin = !full || wb_allowout;
    assign wb_valid    = full;
    assign accept      = mem_valid && mem_allowin;

    assign word_idx = mem_mem_addr[AW+LANE_IDX_W-1:LANE_IDX_W];
    assign byte_off = mem_mem_addr[LANE_IDX_W-1:0];

    // Store data moves up to the addressed byte lane
    assign store_lanes = mem_rs2_data << {byte_off, 3'b000};

    always_ff @(posedge I_sys_clk) begin
        if (accept && mem_mem_wen) begin
            for (int i = 0; i < LANES; i++) begin
                if (mem_wstrb[i])
                    dmem[word_idx][8*i +: 8] <= store_lanes[8*i +: 8];
            end
        end
    end

    assign rd_word    = dmem[word_idx];
    assign rd_shifted = rd_word >> {byte_off, 3'b000};
    assign low_mask   = mem_rstrb[LANES-1:0] >> byte_off;

    always_comb begin
        case (low_mask)
            8'h01:   load_sign = rd_shifted[7];
            8'h03:   load_sign = rd_shifted[15];
            8'h0f:   load_sign = rd_shifted[31];
            default: load_sign = rd_shifted[63];
        endcase
    end

    // Bytes above the access size take the sign or zero
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            if (low_mask[j])
                load_data[8*j +: 8] = rd_shifted[8*j +: 8];
            else
                load_data[8*j +: 8] = {8{mem_rstrb[LANES] & load_sign}};
        end
    end

    always_comb begin
        case (mem_regin_sel)
            SEL_ALU:  wb_next = mem_alu_out;
            SEL_LOAD: wb_next = load_data;
            SEL_LINK: wb_next = mem_pc + xlen_t'(4);
            default:  wb_next = '0;
        endcase
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            full       <= 1'b0;
            wb_reg_wen <= 1'b0;
        end else if (mem_allowin) begin
            full <= mem_valid;
            if (mem_valid)
                wb_reg_wen <= mem_reg_wen;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (accept) begin
            wb_rd   <= mem_rd_addr;
            wb_data <= wb_next;
        end
    end

    assign access_strb = mem_wstrb | mem_rstrb[LANES-1:0];

    // Write strobes from ex_stage only come with a store
    a_wstrb_store: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        mem_valid |-> (mem_wstrb == '0) || mem_mem_wen);

    a_aligned: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        accept && (access_strb != '0) |->
            access_strb[byte_off] && $onehot($countones(access_strb)) &&
            ((byte_off & ($countones(access_strb) - 1)) == 0));

endmodule

//--- hdl/ex_mem_top.sv
`timescale 1ns/10ps

module ex_mem_top
    import rv_isa_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int DMEM_WORDS = DMEM_WORDS_DFLT
) (
    input  logic      I_sys_clk,
    input  logic      I_rst,
    input  logic      issue_valid,
    output logic      issue_allowin,
    input  alu_op_e   issue_op,
    input  mem_cmd_e  issue_cmd,
    input  mem_size_e issue_size,
    input  logic      issue_unsigned,
    input  logic      issue_link,
    input  xlen_t     issue_src1,
    input  xlen_t     issue_src2,
    input  xlen_t     issue_imm,
    input  xlen_t     issue_pc,
    input  reg_idx_t  issue_rd,
    output logic      wb_valid,
    input  logic      wb_allowout,
    output logic      wb_reg_wen,
    output reg_idx_t  wb_rd,
    output xlen_t     wb_data
);

    logic       ex_valid;
    logic       ex_allowin;
    xlen_t      ex_alu_out;
    xlen_t      ex_mem_addr;
    xlen_t      ex_rs2_data;
    xlen_t      ex_pc;
    wstrb_t     ex_wstrb;
    rstrb_t     ex_rstrb;
    logic       ex_mem_wen;
    logic       ex_reg_wen;
    reg_idx_t   ex_rd_addr;
    regin_sel_e ex_regin_sel;

    logic       mem_valid;
    logic       mem_allowin;
    xlen_t      mem_alu_out;
    xlen_t      mem_mem_addr;
    xlen_t      mem_rs2_data;
    xlen_t      mem_pc;
    wstrb_t     mem_wstrb;
    rstrb_t     mem_rstrb;
    logic       mem_mem_wen;
    logic       mem_reg_wen;
    reg_idx_t   mem_rd_addr;
    regin_sel_e mem_regin_sel;

    ex_stage u_ex_stage (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .issue_valid    (issue_valid),
        .issue_allowin  (issue_allowin),
        .issue_op       (issue_op),
        .issue_cmd      (issue_cmd),
        .issue_size     (issue_size),
        .issue_unsigned (issue_unsigned),
        .issue_link     (issue_link),
        .issue_src1     (issue_src1),
        .issue_src2     (issue_src2),
        .issue_imm      (issue_imm),
        .issue_pc       (issue_pc),
        .issue_rd       (issue_rd),
        .ex_allowin     (ex_allowin),
        .ex_valid       (ex_valid),
        .alu_out        (ex_alu_out),
        .mem_addr       (ex_mem_addr),
        .rs2_data       (ex_rs2_data),
        .pc             (ex_pc),
        .wstrb          (ex_wstrb),
        .rstrb          (ex_rstrb),
        .mem_wen        (ex_mem_wen),
        .reg_wen        (ex_reg_wen),
        .rd_addr        (ex_rd_addr),
        .regin_sel      (ex_regin_sel)
    );

    ex_mem_reg u_ex_mem_reg (
        .I_sys_clk     (I_sys_clk),
        .I_rst         (I_rst),
        .ex_valid      (ex_valid),
        .ex_allowin    (ex_allowin),
        .ex_alu_out    (ex_alu_out),
        .ex_mem_addr   (ex_mem_addr),
        .ex_rs2_data   (ex_rs2_data),
        .ex_wstrb      (ex_wstrb),
        .ex_rstrb      (ex_rstrb),
        .ex_mem_wen    (ex_mem_wen),
        .ex_reg_wen    (ex_reg_wen),
        .ex_rd_addr    (ex_rd_addr),
        .ex_regin_sel  (ex_regin_sel),
        .ex_pc         (ex_pc),
        .mem_valid     (mem_valid),
        .mem_allowin   (mem_allowin),
        .mem_alu_out   (mem_alu_out),
        .mem_mem_addr  (mem_mem_addr),
        .mem_rs2_data  (mem_rs2_data),
        .mem_wstrb     (mem_wstrb),
        .mem_rstrb     (mem_rstrb),
        .mem_mem_wen   (mem_mem_wen),
        .mem_reg_wen   (mem_reg_wen),
        .mem_rd_addr   (mem_rd_addr),
        .mem_regin_sel (mem_regin_sel),
        .mem_pc        (mem_pc)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_stage (
        .I_sys_clk     (I_sys_clk),
        .I_rst         (I_rst),
        .mem_valid     (mem_valid),
        .mem_allowin   (mem_allowin),
        .mem_alu_out   (mem_alu_out),
        .mem_mem_addr  (mem_mem_addr),
        .mem_rs2_data  (mem_rs2_data),
        .mem_wstrb     (mem_wstrb),
        .mem_rstrb     (mem_rstrb),
        .mem_mem_wen   (mem_mem_wen),
        .mem_reg_wen   (mem_reg_wen),
        .mem_rd_addr   (mem_rd_addr),
        .mem_regin_sel (mem_regin_sel),
        .mem_pc        (mem_pc),
        .wb_valid      (wb_valid),
        .wb_allowout   (wb_allowout),
        .wb_reg_wen    (wb_reg_wen),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

//--- tb/tb_ex_mem_top.sv
`timescale 1ns/10ps

module tb_ex_mem_top
    import rv_isa_pkg::*;
();

    localparam int          MAX_TESTS = 64;
    localparam int          LATENCY   = 3;
    localparam logic [31:0] SEED      = 32'h24b6_b414;

    logic      I_sys_clk;
    logic      I_rst;
    logic      issue_valid;
    logic      issue_allowin;
    alu_op_e   issue_op;
    mem_cmd_e  issue_cmd;
    mem_size_e issue_size;
    logic      issue_unsigned;
    logic      issue_link;
    xlen_t     issue_src1;
    xlen_t     issue_src2;
    xlen_t     issue_imm;
    xlen_t     issue_pc;
    reg_idx_t  issue_rd;
    logic      wb_valid;
    logic      wb_allowout;
    logic      wb_reg_wen;
    reg_idx_t  wb_rd;
    xlen_t     wb_data;

    // Test table as read from the file
    logic [3:0] t_op       [MAX_TESTS];
    logic [1:0] t_cmd      [MAX_TESTS];
    logic [1:0] t_size     [MAX_TESTS];
    logic       t_unsigned [MAX_TESTS];
    logic       t_link     [MAX_TESTS];
    xlen_t      t_src1     [MAX_TESTS];
    xlen_t      t_src2     [MAX_TESTS];
    xlen_t      t_imm      [MAX_TESTS];
    xlen_t      t_pc       [MAX_TESTS];
    reg_idx_t   t_rd       [MAX_TESTS];
    logic       t_wen      [MAX_TESTS];
    xlen_t      t_data     [MAX_TESTS];

    // Outstanding operations in issue order
    int exp_idx_q   [$];
    int exp_cyc_q   [$];
    bit exp_timed_q [$];

    int          n_tests         = 0;
    int          cur_idx         = 0;
    int          cyc             = 0;
    int          retired         = 0;
    int          val_errs        = 0;
    int          other_errs      = 0;
    int          watchdog_cycles = 0;
    bit          stall_en        = 1'b0;
    bit          timed_phase     = 1'b1;

    ex_mem_top u_ex_mem_top (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .issue_valid    (issue_valid),
        .issue_allowin  (issue_allowin),
        .issue_op       (issue_op),
        .issue_cmd      (issue_cmd),
        .issue_size     (issue_size),
        .issue_unsigned (issue_unsigned),
        .issue_link     (issue_link),
        .issue_src1     (issue_src1),
        .issue_src2     (issue_src2),
        .issue_imm      (issue_imm),
        .issue_pc       (issue_pc),
        .issue_rd       (issue_rd),
        .wb_valid       (wb_valid),
        .wb_allowout    (wb_allowout),
        .wb_reg_wen     (wb_reg_wen),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    always #2 I_sys_clk = ~I_sys_clk;

    // Writeback stalls on about a third of cycles when enabled
    always @(negedge I_sys_clk) begin
        if (stall_en)
            wb_allowout = ($urandom % 3) != 0;
        else
            wb_allowout = 1'b1;
    end

    task automatic load_tests(output bit ok);
        int          fd;
        int          code;
        string       line;
        logic [63:0] f [12];
        ok = 1'b0;
        fd = $fopen("tb/ex_mem_tests.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            if (code != 12) begin
                other_errs++;
                $display("Malformed line in test file: %s", line);
                continue;
            end
            t_op[n_tests]       = f[0][3:0];
            t_cmd[n_tests]      = f[1][1:0];
            t_size[n_tests]     = f[2][1:0];
            t_unsigned[n_tests] = f[3][0];
            t_link[n_tests]     = f[4][0];
            t_src1[n_tests]     = f[5];
            t_src2[n_tests]     = f[6];
            t_imm[n_tests]      = f[7];
            t_pc[n_tests]       = f[8];
            t_rd[n_tests]       = f[9][4:0];
            t_wen[n_tests]      = f[10][0];
            t_data[n_tests]     = f[11];
            n_tests++;
        end
        $fclose(fd);
        ok = (n_tests > 0);
    endtask

    task automatic drive_test(input int i);
        issue_valid    = 1'b1;
        issue_op       = alu_op_e'(t_op[i]);
        issue_cmd      = mem_cmd_e'(t_cmd[i]);
        issue_size     = mem_size_e'(t_size[i]);
        issue_unsigned = t_unsigned[i];
        issue_link     = t_link[i];
        issue_src1     = t_src1[i];
        issue_src2     = t_src2[i];
        issue_imm      = t_imm[i];
        issue_pc       = t_pc[i];
        issue_rd       = t_rd[i];
        cur_idx        = i;
    endtask

    // Back-to-back issue of the whole table
    task automatic issue_pass(input bit stalls);
        for (int i = 0; i < n_tests; i++) begin
            @(negedge I_sys_clk);
            drive_test(i);
            @(posedge I_sys_clk);
            while (!issue_allowin) begin
                if (!stalls) begin
                    other_errs++;
                    $display("Issue of test %0d held off while writeback never stalled", i);
                end
                @(posedge I_sys_clk);
            end
        end
        @(negedge I_sys_clk);
        issue_valid = 1'b0;
    endtask

    task automatic drain_results();
        while (exp_idx_q.size() != 0)
            @(posedge I_sys_clk);
    endtask

    task automatic check_writeback();
        int idx;
        int lat;
        if (exp_idx_q.size() == 0) begin
            other_errs++;
            $display("Writeback at cycle %0d with no operation outstanding", cyc);
            return;
        end
        idx = exp_idx_q.pop_front();
        lat = cyc - exp_cyc_q.pop_front();
        retired++;
        if (wb_reg_wen !== t_wen[idx]) begin
            val_errs++;
            $display("ERR wb_reg_wen test %0d: expected %h actual %h", idx, t_wen[idx], wb_reg_wen);
        end
        if (wb_rd !== t_rd[idx]) begin
            val_errs++;
            $display("ERR wb_rd test %0d: expected %h actual %h", idx, t_rd[idx], wb_rd);
        end
        if (wb_data !== t_data[idx]) begin
            val_errs++;
            $display("ERR wb_data test %0d: expected %h actual %h", idx, t_data[idx], wb_data);
        end
        if (exp_timed_q.pop_front() && lat != LATENCY) begin
            val_errs++;
            $display("ERR wb latency test %0d: expected %h actual %h", idx, LATENCY, lat);
        end
    endtask

    // Values read here are the ones present before the edge
    always @(posedge I_sys_clk) begin
        if (!I_rst) begin
            if (!issue_allowin && !(exp_idx_q.size() == LATENCY && wb_valid && !wb_allowout)) begin
                other_errs++;
                $display("issue_allowin low at cycle %0d without a full stalled pipeline", cyc);
            end
            if (wb_valid && wb_allowout)
                check_writeback();
            if (issue_valid && issue_allowin) begin
                exp_idx_q.push_back(cur_idx);
                exp_cyc_q.push_back(cyc);
                exp_timed_q.push_back(timed_phase);
            end
            cyc++;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge I_sys_clk);
        $display("Timeout after %0d cycles with %0d results outstanding", watchdog_cycles,
            exp_idx_q.size());
        $display("Value errors: %0d, other errors: %0d", val_errs, other_errs + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        bit ok;
        I_sys_clk      = 1'b0;
        I_rst          = 1'b1;
        issue_valid    = 1'b0;
        issue_op       = ALU_ADD;
        issue_cmd      = CMD_NONE;
        issue_size     = SIZE_B;
        issue_unsigned = 1'b0;
        issue_link     = 1'b0;
        issue_src1     = '0;
        issue_src2     = '0;
        issue_imm      = '0;
        issue_pc       = '0;
        issue_rd       = '0;
        wb_allowout    = 1'b1;
        void'($urandom(SEED));
        load_tests(ok);
        if (!ok) begin
            $display("No tests could be read from tb/ex_mem_tests.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            // Two passes over the table, each with its own margin
            watchdog_cycles = 2 * n_tests * 20 + 100;
            repeat (3) @(posedge I_sys_clk);
            @(negedge I_sys_clk);
            I_rst = 1'b0;
            if (wb_valid !== 1'b0) begin
                val_errs++;
                $display("ERR wb_valid after reset: expected %h actual %h", 1'b0, wb_valid);
            end
            if (issue_allowin !== 1'b1) begin
                val_errs++;
                $display("ERR issue_allowin after reset: expected %h actual %h", 1'b1,
                    issue_allowin);
            end
            issue_pass(1'b0);
            drain_results();
            @(negedge I_sys_clk);
            timed_phase = 1'b0;
            stall_en    = 1'b1;
            issue_pass(1'b1);
            drain_results();
            stall_en = 1'b0;
            repeat (5) @(negedge I_sys_clk);
            if (wb_valid !== 1'b0) begin
                val_errs++;
                $display("ERR wb_valid when idle: expected %h actual %h", 1'b0, wb_valid);
            end
            if (retired != 2 * n_tests) begin
                other_errs++;
                $display("Only %0d of %0d results were written back", retired, 2 * n_tests);
            end
            $display("Value errors: %0d, other errors: %0d", val_errs, other_errs);
            if (val_errs == 0 && other_errs == 0)
                $display("Done: no errors");
            else
                $display("Done: errors found");
            $finish;
        end
    end

endmodule

//--- tb/ex_mem_tests.txt
# op cmd size unsigned link src1 src2 imm pc rd exp_reg_wen exp_data (all hex)
# op 0 add 1 sub 2 and 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu, cmd 1 load 2 store
0 0 0 0 0 0000000000000005 0000000000000007 0000000000000000 0000000000000000 01 1 000000000000000c
1 0 0 0 0 0000000000000005 0000000000000007 0000000000000000 0000000000000000 02 1 fffffffffffffffe
2 0 0 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0000000000000000 0000000000000000 03 1 f000f000f000f000
4 0 0 0 0 123456789abcdef0 ffffffffffffffff 0000000000000000 0000000000000000 04 1 edcba9876543210f
5 0 0 0 0 00000000000000ff 0000000000000108 0000000000000000 0000000000000000 05 1 000000000000ff00
6 0 0 0 0 8000000000000000 0000000000000004 0000000000000000 0000000000000000 06 1 0800000000000000
7 0 0 0 0 8000000000000000 0000000000000004 0000000000000000 0000000000000000 07 1 f800000000000000
8 0 0 0 0 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 08 1 0000000000000001
9 0 0 0 0 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 09 1 0000000000000000
0 0 0 0 0 0000000000000001 0000000000000001 0000000000000000 0000000000000000 00 0 0000000000000002
0 2 3 0 0 0000000000000040 0123456789abcdef 0000000000000000 0000000000000000 0a 0 0000000000000000
0 2 3 0 0 0000000000000048 1122334455667788 0000000000000000 0000000000000000 0b 0 0000000000000000
0 2 0 0 0 0000000000000048 000000000000009a 0000000000000003 0000000000000000 0c 0 0000000000000000
0 2 1 0 0 0000000000000050 0000000000008765 fffffffffffffffc 0000000000000000 0d 0 0000000000000000
0 2 3 0 0 0000000000000050 fedcba9876543210 0000000000000000 0000000000000000 0e 0 0000000000000000
0 2 2 0 0 0000000000000050 0000000080c0ffee 0000000000000004 0000000000000000 0f 0 0000000000000000
0 1 3 0 0 0000000000000040 0000000000000000 0000000000000000 0000000000000000 10 1 0123456789abcdef
0 1 0 0 0 0000000000000048 0000000000000000 0000000000000003 0000000000000000 11 1 ffffffffffffff9a
0 1 0 1 0 0000000000000048 0000000000000000 0000000000000003 0000000000000000 12 1 000000000000009a
0 1 1 0 0 000000000000004c 0000000000000000 0000000000000000 0000000000000000 13 1 ffffffffffff8765
0 1 1 1 0 000000000000004c 0000000000000000 0000000000000000 0000000000000000 14 1 0000000000008765
0 1 2 0 0 0000000000000054 0000000000000000 0000000000000000 0000000000000000 15 1 ffffffff80c0ffee
0 1 2 1 0 0000000000000054 0000000000000000 0000000000000000 0000000000000000 16 1 0000000080c0ffee
0 1 0 0 0 0000000000000040 0000000000000000 0000000000000008 0000000000000000 17 1 ffffffffffffff88
0 1 1 0 0 000000000000004a 0000000000000000 0000000000000000 0000000000000000 18 1 ffffffffffff9a66
0 1 3 0 0 0000000000000048 0000000000000000 0000000000000000 0000000000000000 00 0 112287659a667788
0 0 0 0 1 0000000000000000 0000000000000000 0000000000000000 0000000080001000 01 1 0000000080001004
0 0 0 0 1 0000000000000000 0000000000000000 0000000000000000 fffffffffffffffc 1f 1 0000000000000000

//--- vlog.f
hdl/rv_isa_pkg.sv
hdl/mem_access_pkg.sv
hdl/ex_stage.sv
hdl/ex_mem_reg.sv
hdl/mem_stage.sv
hdl/ex_mem_top.sv
tb/tb_ex_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the EX/MEM testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
    --top-module tb_ex_mem_top \
    -f vlog.f \
    -o sim_tb_ex_mem_top

./obj_dir/sim_tb_ex_mem_top | tee sim.log

# The run passes only if the testbench printed its pass line
grep -qx "Done: no errors" sim.log
echo "Simulation passed"
